//--- project.f
arbiter_pkg.sv
queue_head_if.sv
fifo_queue.sv
request_queue_bank.sv
rr_picker.sv
issue_stage.sv
priority_arbiter.sv
tb_priority_arbiter.sv

//--- Makefile
sim:
	verilator --binary --timing -Wno-fatal --top-module tb_priority_arbiter -f project.f -o tb_sim
	./obj_dir/tb_sim > sim.log
	cat sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb_priority_arbiter.sv
module tb_priority_arbiter
    import arbiter_pkg::*;
();

    localparam int wait_limit = 100;

    logic                                       clk_in;
    logic                                       reset_in;
    logic [num_request * request_width - 1 : 0] request_in;
    logic [num_request - 1 : 0]                 request_valid_in;
    logic [num_request - 1 : 0]                 request_critical_in;
    logic [num_request - 1 : 0]                 issue_ack_out;
    payload_t                                   request_out;
    logic                                       request_valid_out;
    logic                                       issue_ack_in;

    // reference model of the queues and the output register
    logic [entry_width - 1 : 0] model_entry [num_request][queue_depth];
    int                         model_count [num_request];
    int                         model_last;
    logic                       model_valid;
    payload_t                   model_payload;
    logic [num_request - 1 : 0] head_mask;
    logic [num_request - 1 : 0] critical_mask;

    logic [31:0] lcg_state = 32'h952b_1361;
    string       current_test;
    int          error_count;
    int          test_errors;
    int          tests_failed;
    int          accepted_count;
    int          served_count;

    priority_arbiter uut (.*);

    initial
    begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // first set bit in circular order after start
    function automatic int rotate_pick(input logic [num_request - 1 : 0] mask, input int start);
        int idx;
        idx = start;
        for (int step = 0; step < num_request; step++)
        begin
            idx = (idx + 1) % num_request;
            if (mask[idx])
                return idx;
        end
        return start;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else
        begin
            $display("MISMATCH %s %s: expected %h, actual %h", current_test, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("%s: timed out waiting for %s", current_test, what);
        error_count++;
    endtask

    task automatic start_test(input string name);
        current_test = name;
        test_errors = error_count;
    endtask

    task automatic finish_test();
        if (error_count == test_errors)
            $display("%s: passed", current_test);
        else
        begin
            $display("%s: failed with %0d errors", current_test, error_count - test_errors);
            tests_failed++;
        end
    endtask

    // the model steps on every edge, from the values seen before the edge
    always @(posedge clk_in)
    begin
        if (reset_in)
        begin
            for (int i = 0; i < num_request; i++)
                model_count[i] = 0;
            model_last = 0;
            model_valid = 1'b0;
        end
        else
        begin
            check_value("request_valid_out", 32'(model_valid), 32'(request_valid_out));
            if (model_valid)
                check_value("request_out", model_payload, request_out);
            for (int i = 0; i < num_request; i++)
                check_value("issue_ack_out", 32'(model_count[i] < queue_depth),
                            32'(issue_ack_out[i]));
            if (model_valid && issue_ack_in)
            begin
                for (int k = 1; k < queue_depth; k++)
                    model_entry[model_last][k - 1] = model_entry[model_last][k];
                model_count[model_last]--;
                model_valid = 1'b0;
                served_count++;
            end
            else if (!model_valid)
            begin
                for (int i = 0; i < num_request; i++)
                begin
                    head_mask[i] = (model_count[i] > 0);
                    critical_mask[i] = head_mask[i] && (model_entry[i][0][request_width]
                                       || model_count[i] == queue_depth);
                end
                if (critical_mask != '0)
                    model_last = rotate_pick(critical_mask, model_last);
                else if (head_mask != '0)
                    model_last = rotate_pick(head_mask, model_last);
                model_valid = (head_mask != '0);
                model_payload = model_entry[model_last][0][request_width - 1 : 0];
            end
            for (int i = 0; i < num_request; i++)
            begin
                if (request_valid_in[i] && issue_ack_out[i] && model_count[i] < queue_depth)
                begin
                    model_entry[i][model_count[i]] = {request_critical_in[i],
                        request_in[i * request_width +: request_width]};
                    model_count[i]++;
                    accepted_count++;
                end
            end
        end
    end

    task automatic push_request(input int idx, input logic critical);
        int   waited;
        logic accepted;
        request_in[idx * request_width +: request_width] <= next_random();
        request_critical_in[idx] <= critical;
        request_valid_in[idx] <= 1'b1;
        waited = 0;
        accepted = 1'b0;
        while (!accepted && waited < wait_limit)
        begin
            @(posedge clk_in);
            accepted = issue_ack_out[idx];
            waited++;
        end
        request_valid_in[idx] <= 1'b0;
        if (!accepted)
            report_timeout("issue_ack_out");
    endtask

    task automatic serve_one(input int hold);
        int waited;
        waited = 0;
        @(posedge clk_in);
        while (!request_valid_out && waited < wait_limit)
        begin
            @(posedge clk_in);
            waited++;
        end
        if (!request_valid_out)
            report_timeout("request_valid_out");
        else
        begin
            repeat (hold) @(posedge clk_in);
            issue_ack_in <= 1'b1;
            @(posedge clk_in);
            issue_ack_in <= 1'b0;
        end
    endtask

    initial
    begin
        logic [31:0] rnd;
        int          waited;
        reset_in = 1'b1;
        request_in = '0;
        request_valid_in = '0;
        request_critical_in = '0;
        issue_ack_in = 1'b0;
        repeat (3) @(posedge clk_in);
        reset_in <= 1'b0;

        start_test("after_reset");
        @(posedge clk_in);
        check_value("request_out", '0, request_out);
        check_value("issue_ack_out", 32'({num_request{1'b1}}), 32'(issue_ack_out));
        finish_test();

        start_test("single_requester");
        push_request(1, 1'b0);
        push_request(1, 1'b0);
        serve_one(2);
        serve_one(0);
        finish_test();

        // top-ups keep every queue at one entry, so nothing gets promoted
        start_test("round_robin");
        for (int i = 0; i < num_request; i++)
            push_request(i, 1'b0);
        for (int n = 0; n < 6; n++)
        begin
            serve_one(0);
            push_request(model_last, 1'b0);
        end
        repeat (num_request) serve_one(0);
        finish_test();

        start_test("critical_first");
        push_request(0, 1'b0);
        push_request(1, 1'b0);
        push_request(2, 1'b1);
        push_request(0, 1'b1);
        repeat (4) serve_one(0);
        push_request(2, 1'b0);
        push_request(0, 1'b0);
        push_request(1, 1'b0);
        push_request(1, 1'b0);
        repeat (4) serve_one(0);
        finish_test();

        start_test("backpressure");
        push_request(2, 1'b0);
        push_request(0, 1'b1);
        serve_one(5);
        serve_one(3);
        push_request(1, 1'b0);
        serve_one(1);
        finish_test();

        start_test("random_traffic");
        for (int n = 0; n < 400; n++)
        begin
            @(posedge clk_in);
            for (int i = 0; i < num_request; i++)
            begin
                // a requester holds its request until its queue takes it
                if (!request_valid_in[i] || issue_ack_out[i])
                begin
                    rnd = next_random();
                    request_valid_in[i] <= (rnd[31:30] != 2'b00);
                    request_critical_in[i] <= (rnd[29:27] == 3'b000);
                    request_in[i * request_width +: request_width] <= next_random();
                end
            end
            rnd = next_random();
            issue_ack_in <= (rnd[31:30] != 2'b00);
        end
        issue_ack_in <= 1'b1;
        waited = 0;
        @(negedge clk_in);
        while ((request_valid_in != '0 || accepted_count != served_count) && waited < wait_limit)
        begin
            @(posedge clk_in);
            request_valid_in <= request_valid_in & ~issue_ack_out;
            @(negedge clk_in);
            waited++;
        end
        if (request_valid_in != '0 || accepted_count != served_count)
            report_timeout("the queues to drain");
        @(posedge clk_in);
        issue_ack_in <= 1'b0;
        finish_test();

        $display("6 tests, %0d failed, %0d errors", tests_failed, error_count);
        if (error_count == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- priority_arbiter.sv
module priority_arbiter
    import arbiter_pkg::*;
(
    input  logic                                   clk_in,
    input  logic                                   reset_in,

    input  logic [num_request * request_width - 1 : 0] request_in,
    input  logic [num_request - 1 : 0]             request_valid_in,
    input  logic [num_request - 1 : 0]             request_critical_in,
    output logic [num_request - 1 : 0]             issue_ack_out,

    output payload_t                               request_out,
    output logic                                   request_valid_out,
    input  logic                                   issue_ack_in
);

    queue_head_if heads ();

    payload_t                   request_payload [num_request];
    logic [num_request - 1 : 0] critical_mask;

    req_index_t last_served;
    req_index_t valid_pick;
    req_index_t critical_pick;
    logic       valid_found;
    logic       critical_found;

    for (genvar i = 0; i < num_request; i++)
    begin : g_split
        assign request_payload[i] = request_in[i * request_width +: request_width];
    end

    request_queue_bank u_bank
    (
        .clk_in              (clk_in),
        .reset_in            (reset_in),
        .request_in          (request_payload),
        .request_valid_in    (request_valid_in),
        .request_critical_in (request_critical_in),
        .issue_ack_out       (issue_ack_out),
        .heads               (heads.bank)
    );

    assign critical_mask = heads.head_valid & heads.head_critical;

    rr_picker u_valid_picker
    (
        .mask        (heads.head_valid),
        .start_after (last_served),
        .pick        (valid_pick),
        .found       (valid_found)
    );

    rr_picker u_critical_picker
    (
        .mask        (critical_mask),
        .start_after (last_served),
        .pick        (critical_pick),
        .found       (critical_found)
    );

    issue_stage u_issue
    (
        .clk_in            (clk_in),
        .reset_in          (reset_in),
        .heads             (heads.issue),
        .valid_pick        (valid_pick),
        .valid_found       (valid_found),
        .critical_pick     (critical_pick),
        .critical_found    (critical_found),
        .last_served       (last_served),
        .request_out       (request_out),
        .request_valid_out (request_valid_out),
        .issue_ack_in      (issue_ack_in)
    );

endmodule

//--- issue_stage.sv
module issue_stage
    import arbiter_pkg::*;
(
    input  logic        clk_in,
    input  logic        reset_in,

    queue_head_if.issue heads,

    input  req_index_t  valid_pick,
    input  logic        valid_found,
    input  req_index_t  critical_pick,
    input  logic        critical_found,

    output req_index_t  last_served,

    output payload_t    request_out,
    output logic        request_valid_out,
    input  logic        issue_ack_in
);

    req_index_t chosen;
    logic       accept;

    // critical mask is a subset of the valid mask
    assign chosen = critical_found ? critical_pick : valid_pick;

    assign accept = request_valid_out & issue_ack_in;

    // only the queue being served is popped
    always_comb
    begin
        for (int i = 0; i < num_request; i++)
        begin
            heads.pop[i] = accept && (last_served == req_index_t'(i));
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            request_out       <= '0;
            request_valid_out <= 1'b0;
            last_served       <= '0;
        end
        else if (!request_valid_out)
        begin
            if (valid_found)
            begin
                request_out       <= heads.head_payload[chosen];
                request_valid_out <= 1'b1;
                last_served       <= chosen;
            end
        end
        else if (issue_ack_in)
        begin
            // one idle cycle while the served queue moves up its next head
            request_out       <= '0;
            request_valid_out <= 1'b0;
        end
    end

endmodule

//--- rr_picker.sv
module rr_picker
    import arbiter_pkg::*;
(
    input  logic [num_request - 1 : 0] mask,
    input  req_index_t                 start_after,
    output req_index_t                 pick,
    output logic                       found
);

    // circular search, one past start_after first, start_after itself last
    always_comb
    begin
        int position;

        pick  = '0;
        found = 1'b0;
        for (int offset = 1; offset <= num_request; offset++)
        begin
            position = (int'(start_after) + offset) % num_request;
            if (!found && mask[position])
            begin
                pick  = req_index_t'(position);
                found = 1'b1;
            end
        end
    end

endmodule

//--- request_queue_bank.sv
module request_queue_bank
    import arbiter_pkg::*;
(
    input  logic                       clk_in,
    input  logic                       reset_in,

    input  payload_t                   request_in [num_request],
    input  logic [num_request - 1 : 0] request_valid_in,
    input  logic [num_request - 1 : 0] request_critical_in,
    output logic [num_request - 1 : 0] issue_ack_out,

    queue_head_if.bank                 heads
);

    logic [entry_width - 1 : 0] head_entry [num_request];
    logic [num_request - 1 : 0] stored_critical;
    logic [num_request - 1 : 0] queue_full;

    for (genvar i = 0; i < num_request; i++)
    begin : g_queue
        fifo_queue
        #(
            .depth       (queue_depth),
            .width       (entry_width)
        )
        u_fifo
        (
            .clk_in      (clk_in),
            .reset_in    (reset_in),
            .write_data  ({request_critical_in[i], request_in[i]}),
            .write_valid (request_valid_in[i]),
            .write_ack   (issue_ack_out[i]),
            .read_data   (head_entry[i]),
            .read_valid  (heads.head_valid[i]),
            .pop         (heads.pop[i]),
            .full        (queue_full[i])
        );

        assign heads.head_payload[i] = head_entry[i][request_width - 1 : 0];
        assign stored_critical[i]    = head_entry[i][entry_width - 1];

        // a full queue is promoted so its requester is not held off for long
        assign heads.head_critical[i] = stored_critical[i] | queue_full[i];
    end

endmodule

//--- fifo_queue.sv
module fifo_queue
    import arbiter_pkg::*;
#(
    parameter int depth = queue_depth,
    parameter int width = $bits(payload_t) + 1
)
(
    input  logic                 clk_in,
    input  logic                 reset_in,

    input  logic [width - 1 : 0] write_data,
    input  logic                 write_valid,
    output logic                 write_ack,

    output logic [width - 1 : 0] read_data,
    output logic                 read_valid,
    input  logic                 pop,

    output logic                 full
);

    localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_width = $clog2(depth + 1);

    logic [width - 1 : 0]       entries [depth];
    logic [ptr_width - 1 : 0]   write_ptr;
    logic [ptr_width - 1 : 0]   read_ptr;
    logic [count_width - 1 : 0] count;

    logic write_fire;
    logic pop_fire;

    assign full       = (count == count_width'(depth));
    assign write_ack  = ~full;
    assign read_valid = (count != '0);
    assign read_data  = entries[read_ptr];

    assign write_fire = write_valid & write_ack;
    assign pop_fire   = pop & read_valid;

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            write_ptr <= '0;
            read_ptr  <= '0;
            count     <= '0;
        end
        else
        begin
            if (write_fire)
            begin
                write_ptr <= write_ptr + 1'b1;
            end
            if (pop_fire)
            begin
                read_ptr <= read_ptr + 1'b1;
            end
            if (write_fire && !pop_fire)
            begin
                count <= count + 1'b1;
            end
            else if (pop_fire && !write_fire)
            begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (write_fire)
        begin
            entries[write_ptr] <= write_data;
        end
    end

endmodule

//--- queue_head_if.sv
interface queue_head_if
    import arbiter_pkg::*;
();

    // head entry of every requester queue
    payload_t                   head_payload [num_request];
    logic [num_request - 1 : 0] head_valid;

    // stored flag or full queue
    logic [num_request - 1 : 0] head_critical;

    // removes the head at the next rising edge
    logic [num_request - 1 : 0] pop;

    modport bank
    (
        output head_payload,
        output head_valid,
        output head_critical,
        input  pop
    );

    modport issue
    (
        input  head_payload,
        input  head_valid,
        input  head_critical,
        output pop
    );

endinterface

//--- arbiter_pkg.sv
package arbiter_pkg;

    // requester count and payload size
    localparam int num_request = 3;
    localparam int request_width = 32;

    // entries per requester queue, power of two
    localparam int queue_depth = 2;

    // one queue entry is the payload plus its critical flag
    localparam int entry_width = request_width + 1;

    localparam int index_width = (num_request > 1) ? $clog2(num_request) : 1;

    typedef logic [index_width - 1 : 0] req_index_t;

    typedef logic [request_width - 1 : 0] payload_t;

endpackage
